// File: Makefile
# Verilator build and run for the mesh router

RTL = verilog/rtr_pkg.sv verilog/rtr_ip_ctrl.sv verilog/rtr_sw_alloc.sv \
      verilog/rtr_op_ctrl.sv verilog/rtr_err_rpt.sv verilog/rtr_top.sv

.PHONY: all lint clean

all:
	verilator --binary --assert -f filelist.f --top-module tb_rtr_top -o sim
	./obj_dir/sim | tee sim.log
	grep -q "Test passed" sim.log

lint:
	verilator --lint-only -Wall $(RTL) --top-module rtr_top

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
+incdir+tb
verilog/rtr_pkg.sv
verilog/rtr_ip_ctrl.sv
verilog/rtr_sw_alloc.sv
verilog/rtr_op_ctrl.sv
verilog/rtr_err_rpt.sv
verilog/rtr_top.sv
tb/tb_rtr_top.sv

// File: tb/tb_rtr_util.svh
// Router testbench helpers
`ifndef TB_RTR_UTIL_SVH
`define TB_RTR_UTIL_SVH
`default_nettype none

// --------------------------------------------------
// random numbers
// --------------------------------------------------

// 32-bit xorshift step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

// --------------------------------------------------
// flit and route helpers
// --------------------------------------------------

// head flit data, destination in the low address bits
function automatic rtr_pkg::flit_data_t build_head(input rtr_pkg::router_addr_t dst,
                                                   input logic [31:0] payload);
   rtr_pkg::flit_data_t d;
   d = payload;
   d[rtr_pkg::router_addr_width-1:0] = dst;
   return d;
endfunction

// expected output port, x resolved before y
function automatic int ref_route(input rtr_pkg::router_addr_t own,
                                 input rtr_pkg::router_addr_t dst);
   int port;
   if (dst[1:0] < own[1:0])
      port = rtr_pkg::port_xm;
   else if (dst[1:0] > own[1:0])
      port = rtr_pkg::port_xp;
   else if (dst[3:2] < own[3:2])
      port = rtr_pkg::port_ym;
   else if (dst[3:2] > own[3:2])
      port = rtr_pkg::port_yp;
   else
      port = rtr_pkg::port_local;
   return port;
endfunction

`default_nettype wire
`endif

// File: tb/tb_rtr_top.sv
// Mesh router testbench
`include "tb_rtr_util.svh"
`default_nettype none

module tb_rtr_top;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int np = rtr_pkg::num_ports;
   localparam int limit = 2000;

   logic clk;
   logic arst_n;
   rtr_pkg::router_addr_t router_address;
   rtr_pkg::port_vec_t valid_in;
   rtr_pkg::port_vec_t head_in;
   rtr_pkg::port_vec_t tail_in;
   rtr_pkg::flit_data_t [np-1:0] data_in;
   rtr_pkg::port_vec_t flow_out;
   rtr_pkg::port_vec_t valid_out;
   rtr_pkg::port_vec_t head_out;
   rtr_pkg::port_vec_t tail_out;
   rtr_pkg::flit_data_t [np-1:0] data_out;
   rtr_pkg::port_vec_t flow_in;
   logic error;

   // scoreboard state
   logic [31:0] rng;
   int cyc;
   int errors;
   int checks;
   int tests;
   int failed;
   int up_cred[np];
   int sent_cnt[np];
   int pulse_cnt[np];
   logic hold[np];
   int due_q[np][$];
   logic [33:0] rx_q[np][$];
   logic [33:0] exp_q[np][$];
   logic err_test;
   logic done3;

   rtr_top DUT
   (
      .clk               (clk),
      .arst_n            (arst_n),
      .router_address    (router_address),
      .channel_valid_in  (valid_in),
      .channel_head_in   (head_in),
      .channel_tail_in   (tail_in),
      .channel_data_in   (data_in),
      .flow_ctrl_out     (flow_out),
      .channel_valid_out (valid_out),
      .channel_head_out  (head_out),
      .channel_tail_out  (tail_out),
      .channel_data_out  (data_out),
      .flow_ctrl_in      (flow_in),
      .error             (error)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] rand_next();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // --------------------------------------------------
   // monitors and downstream credit model
   // --------------------------------------------------

   always @(posedge clk)
   begin
      cyc++;
      if (arst_n)
      begin
         for (int o = 0; o < np; o++)
         begin
            if (valid_out[o])
            begin
               rx_q[o].push_back({head_out[o], tail_out[o], data_out[o]});
               // credit goes back 1 to 6 cycles later
               due_q[o].push_back(cyc + 1 + int'(rand_next() % 6));
            end
            if (flow_out[o])
            begin
               up_cred[o]++;
               pulse_cnt[o]++;
            end
         end
      end
   end

   always @(negedge clk)
   begin
      for (int o = 0; o < np; o++)
      begin
         flow_in[o] = 1'b0;
         if (arst_n && !hold[o] && due_q[o].size() > 0 && due_q[o][0] <= cyc)
         begin
            flow_in[o] = 1'b1;
            void'(due_q[o].pop_front());
         end
      end
   end

   // --------------------------------------------------
   // checks and waits
   // --------------------------------------------------

   task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      assert (act === exp)
      else
      begin
         $display("ERR t=%0t %s expected %0h got %0h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic wait_rx(input int o, input int n);
      int w;
      w = 0;
      while (rx_q[o].size() < n && w < limit)
      begin
         @(negedge clk);
         w++;
      end
      if (w >= limit)
      begin
         $display("timeout: output %0d delivered %0d of %0d flits", o, rx_q[o].size(), n);
         errors++;
      end
   endtask

   // downstream and upstream credits all home
   task automatic wait_drain();
      int w;
      int busy;
      w = 0;
      busy = 1;
      while (busy != 0 && w < limit)
      begin
         @(negedge clk);
         w++;
         busy = 0;
         for (int o = 0; o < np; o++)
            if (due_q[o].size() != 0 || up_cred[o] != rtr_pkg::buffer_size)
               busy++;
      end
      if (w >= limit)
      begin
         $display("timeout: credits did not return after traffic stopped");
         errors++;
      end
   endtask

   task automatic send_flit(input int p, input logic h, input logic t,
                            input rtr_pkg::flit_data_t d);
      int w;
      w = 0;
      while (up_cred[p] == 0 && w < limit)
      begin
         @(negedge clk);
         w++;
      end
      if (w >= limit)
      begin
         $display("timeout: no upstream credit for input %0d", p);
         errors++;
      end
      else
      begin
         @(negedge clk);
         valid_in[p] = 1'b1;
         head_in[p] = h;
         tail_in[p] = t;
         data_in[p] = d;
         up_cred[p]--;
         sent_cnt[p]++;
         @(negedge clk);
         valid_in[p] = 1'b0;
         head_in[p] = 1'b0;
         tail_in[p] = 1'b0;
      end
   endtask

   task automatic apply_reset();
      @(negedge clk);
      arst_n = 1'b0;
      for (int o = 0; o < np; o++)
      begin
         up_cred[o] = rtr_pkg::buffer_size;
         due_q[o].delete();
         rx_q[o].delete();
         hold[o] = 1'b0;
      end
      repeat (10) @(negedge clk);
      arst_n = 1'b1;
   endtask

   task automatic end_test(input string name, input int err_start);
      tests++;
      if (errors == err_start)
         $display("test %s: ok", name);
      else
      begin
         $display("test %s: %0d errors", name, errors - err_start);
         failed++;
      end
   endtask

   // packets from one input, src tag in the top nibble
   task automatic send_packets(input int src, input int n_pkt);
      int len;
      logic [33:0] f;
      for (int p = 0; p < n_pkt; p++)
      begin
         len = 2 + int'(rand_next() % 4);
         for (int k = 0; k < len; k++)
         begin
            f[31:0] = {4'(src), 4'(p), 8'(k), 12'(rand_next()), 4'h9};
            f[33] = (k == 0);
            f[32] = (k == len - 1);
            exp_q[src].push_back(f);
            send_flit(src, f[33], f[32], f[31:0]);
         end
      end
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------

   initial
   begin
      logic [33:0] f;
      logic [33:0] e;
      rtr_pkg::router_addr_t dst;
      int port;
      int e0;
      int w;
      int src;
      int cur;
      rng = 32'd29685;
      router_address = 4'b1001;
      valid_in = '0;
      head_in = '0;
      tail_in = '0;
      data_in = '0;
      flow_in = '0;
      arst_n = 1'b0;
      err_test = 1'b0;
      done3 = 1'b0;
      for (int o = 0; o < np; o++)
      begin
         sent_cnt[o] = 0;
         pulse_cnt[o] = 0;
      end
      apply_reset();

      // routing, all five directions then random targets
      e0 = errors;
      for (int i = 0; i < 10; i++)
      begin
         case (i)
            0: dst = 4'b1000;
            1: dst = 4'b1011;
            2: dst = 4'b0001;
            3: dst = 4'b1101;
            4: dst = 4'b1001;
            default: dst = rtr_pkg::router_addr_t'(rand_next());
         endcase
         port = ref_route(router_address, dst);
         e = {2'b11, build_head(dst, rand_next())};
         send_flit(rtr_pkg::port_local, 1'b1, 1'b1, e[31:0]);
         wait_rx(port, 1);
         if (rx_q[port].size() > 0)
            check_val("channel_data_out", e, rx_q[port].pop_front());
         for (int o = 0; o < np; o++)
            check_val("rx_count", 0, rx_q[o].size());
      end
      end_test("routing", e0);

      // two sources into the local output
      e0 = errors;
      fork
         send_packets(rtr_pkg::port_xm, 3);
         send_packets(rtr_pkg::port_ym, 3);
      join
      wait_rx(rtr_pkg::port_local, exp_q[0].size() + exp_q[2].size());
      cur = -1;
      while (rx_q[rtr_pkg::port_local].size() > 0)
      begin
         f = rx_q[rtr_pkg::port_local].pop_front();
         src = int'(f[31:28]);
         if (cur < 0)
         begin
            check_val("channel_head_out", 1, f[33]);
            cur = src;
         end
         check_val("packet source", cur, src);
         if (exp_q[src].size() > 0)
            check_val("channel_data_out", exp_q[src].pop_front(), f);
         if (f[32])
            cur = -1;
      end
      check_val("flits left", 0, exp_q[0].size() + exp_q[2].size());
      end_test("packet integrity", e0);

      // back-pressure on x-plus
      e0 = errors;
      hold[rtr_pkg::port_xp] = 1'b1;
      fork
         begin
            for (int i = 0; i < 12; i++)
            begin
               e = {2'b11, build_head(4'b1011, {i[7:0], 24'(rand_next())})};
               exp_q[rtr_pkg::port_local].push_back(e);
               send_flit(rtr_pkg::port_local, 1'b1, 1'b1, e[31:0]);
            end
            done3 = 1'b1;
         end
      join_none
      wait_rx(rtr_pkg::port_xp, rtr_pkg::buffer_size);
      repeat (20) @(negedge clk);
      check_val("flits while held", rtr_pkg::buffer_size, rx_q[rtr_pkg::port_xp].size());
      hold[rtr_pkg::port_xp] = 1'b0;
      wait_rx(rtr_pkg::port_xp, 12);
      w = 0;
      while (!done3 && w < limit)
      begin
         @(negedge clk);
         w++;
      end
      if (w >= limit)
      begin
         $display("timeout: back-pressure sender never finished");
         errors++;
      end
      while (rx_q[rtr_pkg::port_xp].size() > 0 && exp_q[rtr_pkg::port_local].size() > 0)
         check_val("channel_data_out", exp_q[rtr_pkg::port_local].pop_front(),
                   rx_q[rtr_pkg::port_xp].pop_front());
      check_val("rx_count", 0, rx_q[rtr_pkg::port_xp].size());
      end_test("back-pressure", e0);

      // every drained flit returned one credit
      e0 = errors;
      wait_drain();
      for (int o = 0; o < np; o++)
         check_val("flow_ctrl_out pulses", sent_cnt[o], pulse_cnt[o]);
      check_val("error", 0, error);
      end_test("credit return", e0);

      // second head without a tail
      e0 = errors;
      err_test = 1'b1;
      send_flit(rtr_pkg::port_ym, 1'b1, 1'b0, build_head(4'b1001, rand_next()));
      send_flit(rtr_pkg::port_ym, 1'b1, 1'b0, build_head(4'b1001, rand_next()));
      w = 0;
      while (!error && w < limit)
      begin
         @(negedge clk);
         w++;
      end
      if (w >= limit)
      begin
         $display("timeout: error output never rose after the framing fault");
         errors++;
      end
      wait_rx(rtr_pkg::port_local, 2);
      wait_drain();
      repeat (5) @(negedge clk);
      check_val("error", 1, error);
      apply_reset();
      repeat (2) @(negedge clk);
      check_val("error", 0, error);
      end_test("error capture", e0);

      $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
      if (errors == 0)
      begin
         $display("Test passed");
      end
      else
      begin
         $display("Test failed");
      end
      $finish;
   end

   // error must stay low until the error test starts
   always @(posedge clk)
   begin
      if (arst_n && !err_test && error)
      begin
         $display("error output rose before the error test at t=%0t", $time);
         errors++;
         err_test = 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: verilog/rtr_err_rpt.sv
// Router error reporting
`default_nettype none

module rtr_err_rpt
(
   input  wire logic                            clk,
   input  wire logic                            arst_n,
   input  wire logic [3*rtr_pkg::num_ports-1:0] errors_in,
   output logic                                 error
);

   // one sticky bit per source
   logic [3*rtr_pkg::num_ports-1:0] errors_q;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         errors_q <= '0;
      else
         errors_q <= errors_q | errors_in;
   end

   // any captured error raises the flag until reset
   assign error = |errors_q;

endmodule

`default_nettype wire

// File: verilog/rtr_ip_ctrl.sv
// Router input controller
`default_nettype none

module rtr_ip_ctrl
(
   input  wire logic                 clk,
   input  wire logic                 arst_n,
   input  wire rtr_pkg::router_addr_t router_address,
   input  wire logic                 flit_valid,
   input  wire logic                 flit_head,
   input  wire logic                 flit_tail,
   input  wire rtr_pkg::flit_data_t  flit_data,
   input  wire logic                 pop,
   output logic                      req,
   output rtr_pkg::port_vec_t        route,
   output logic                      head_out,
   output logic                      tail_out,
   output rtr_pkg::flit_data_t       data_out,
   output logic                      credit_out,
   output logic                      err_overflow,
   output logic                      err_framing
);

   localparam int ptr_width = $clog2(rtr_pkg::buffer_size);

   // fifo storage, one entry per flit
   rtr_pkg::flit_data_t mem_data [rtr_pkg::buffer_size];
   logic                mem_head [rtr_pkg::buffer_size];
   logic                mem_tail [rtr_pkg::buffer_size];

   logic [ptr_width-1:0] wr_ptr;
   logic [ptr_width-1:0] rd_ptr;
   rtr_pkg::credit_cnt_t count;
   logic                 full;
   logic                 empty;
   logic                 push;
   logic                 do_pop;

   rtr_pkg::pkt_state_e  pkt_state;
   rtr_pkg::port_vec_t   route_head;
   rtr_pkg::port_vec_t   route_q;

   assign full = (count == rtr_pkg::credit_cnt_t'(rtr_pkg::buffer_size));
   assign empty = (count == '0);

   // a flit into a full fifo is dropped and flagged
   assign push = flit_valid & ~full;
   assign do_pop = pop & ~empty;
   assign err_overflow = flit_valid & full;

   // head arriving mid-packet, or body/tail with no packet open
   assign err_framing = flit_valid &
                        ((flit_head & (pkt_state == rtr_pkg::pkt_body)) |
                         (~flit_head & (pkt_state == rtr_pkg::pkt_idle)));

   // --------------------------------------------------
   // flit fifo
   // --------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem_data[wr_ptr] <= flit_data;
         mem_head[wr_ptr] <= flit_head;
         mem_tail[wr_ptr] <= flit_tail;
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         pkt_state <= rtr_pkg::pkt_idle;
         route_q <= '0;
         credit_out <= 1'b0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + rtr_pkg::credit_cnt_t'(push) - rtr_pkg::credit_cnt_t'(do_pop);
         // framing follows the arriving flits
         if (flit_valid)
         begin
            if (flit_tail)
               pkt_state <= rtr_pkg::pkt_idle;
            else if (flit_head)
               pkt_state <= rtr_pkg::pkt_body;
         end
         // body flits reuse the route of their head
         if (do_pop && head_out)
            route_q <= route_head;
         // one credit back upstream per drained flit
         credit_out <= do_pop;
      end
   end

   assign req = ~empty;
   assign head_out = mem_head[rd_ptr];
   assign tail_out = mem_tail[rd_ptr];
   assign data_out = mem_data[rd_ptr];

   // --------------------------------------------------
   // dimension-order routing, x first then y
   // --------------------------------------------------

   always_comb
   begin
      logic [rtr_pkg::dim_addr_width-1:0] dst_x;
      logic [rtr_pkg::dim_addr_width-1:0] dst_y;
      logic [rtr_pkg::dim_addr_width-1:0] own_x;
      logic [rtr_pkg::dim_addr_width-1:0] own_y;
      dst_x = data_out[rtr_pkg::dim_addr_width-1:0];
      dst_y = data_out[rtr_pkg::router_addr_width-1:rtr_pkg::dim_addr_width];
      own_x = router_address[rtr_pkg::dim_addr_width-1:0];
      own_y = router_address[rtr_pkg::router_addr_width-1:rtr_pkg::dim_addr_width];
      route_head = '0;
      if (dst_x < own_x)
         route_head[rtr_pkg::port_xm] = 1'b1;
      else if (dst_x > own_x)
         route_head[rtr_pkg::port_xp] = 1'b1;
      else if (dst_y < own_y)
         route_head[rtr_pkg::port_ym] = 1'b1;
      else if (dst_y > own_y)
         route_head[rtr_pkg::port_yp] = 1'b1;
      else
         route_head[rtr_pkg::port_local] = 1'b1;
   end

   assign route = head_out ? route_head : route_q;

endmodule

`default_nettype wire

// File: verilog/rtr_op_ctrl.sv
// Router output controller
`default_nettype none

module rtr_op_ctrl
(
   input  wire logic                                          clk,
   input  wire logic                                          arst_n,
   input  wire logic                                          grant_valid,
   input  wire rtr_pkg::port_idx_t                            grant_ip,
   input  wire rtr_pkg::port_vec_t                            head_in,
   input  wire rtr_pkg::port_vec_t                            tail_in,
   input  wire rtr_pkg::flit_data_t [rtr_pkg::num_ports-1:0]  data_in,
   input  wire logic                                          flow_ctrl,
   output logic                                               channel_valid,
   output logic                                               channel_head,
   output logic                                               channel_tail,
   output rtr_pkg::flit_data_t                                channel_data,
   output logic                                               credit_avail,
   output logic                                               err_credit
);

   rtr_pkg::credit_cnt_t credit_q;
   rtr_pkg::credit_cnt_t credit_next;
   logic                 credit_full;

   // --------------------------------------------------
   // crossbar column and channel register
   // --------------------------------------------------

   // payload register, qualified by channel_valid
   always_ff @(posedge clk)
   begin
      if (grant_valid)
         channel_data <= data_in[grant_ip];
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         channel_valid <= 1'b0;
         channel_head <= 1'b0;
         channel_tail <= 1'b0;
      end
      else
      begin
         channel_valid <= grant_valid;
         // framing bits only mean something with valid
         channel_head <= grant_valid & head_in[grant_ip];
         channel_tail <= grant_valid & tail_in[grant_ip];
      end
   end

   // --------------------------------------------------
   // downstream credit tracking
   // --------------------------------------------------

   assign credit_full = (credit_q == rtr_pkg::credit_cnt_t'(rtr_pkg::buffer_size));

   // a credit with a full count means downstream returned too many
   assign err_credit = flow_ctrl & credit_full;

   always_comb
   begin
      credit_next = credit_q;
      // ignore the extra credit so the count stays in range
      if (flow_ctrl && !credit_full)
         credit_next = credit_next + 1'b1;
      if (grant_valid)
         credit_next = credit_next - 1'b1;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         credit_q <= rtr_pkg::credit_cnt_t'(rtr_pkg::buffer_size);
      else
         credit_q <= credit_next;
   end

   assign credit_avail = (credit_q != '0);

endmodule

`default_nettype wire

// File: verilog/rtr_pkg.sv
// Router sizes and types
`default_nettype none

package rtr_pkg;

   // --------------------------------------------------
   // mesh geometry
   // --------------------------------------------------

   // 4x4 mesh, two dimensions
   localparam int num_dimensions = 2;
   localparam int num_routers_per_dim = 4;

   // address bits for one dimension
   localparam int dim_addr_width = $clog2(num_routers_per_dim);

   // x in the low bits, y in the high bits
   localparam int router_addr_width = num_dimensions * dim_addr_width;

   // --------------------------------------------------
   // ports
   // --------------------------------------------------

   // two neighbors per dimension plus the local node
   localparam int num_ports = 2 * num_dimensions + 1;

   localparam int port_xm = 0;
   localparam int port_xp = 1;
   localparam int port_ym = 2;
   localparam int port_yp = 3;
   localparam int port_local = 4;

   // --------------------------------------------------
   // flits and buffering
   // --------------------------------------------------

   localparam int flit_data_width = 32;

   // input fifo depth, also the credit count after reset
   localparam int buffer_size = 8;

   // holds 0 up to buffer_size
   localparam int credit_width = $clog2(buffer_size + 1);

   typedef logic [router_addr_width-1:0] router_addr_t;
   typedef logic [flit_data_width-1:0] flit_data_t;
   typedef logic [$clog2(num_ports)-1:0] port_idx_t;
   typedef logic [num_ports-1:0] port_vec_t;
   typedef logic [credit_width-1:0] credit_cnt_t;

   // whether an input is between head and tail
   typedef enum logic
   {
      pkt_idle = 1'b0,
      pkt_body = 1'b1
   } pkt_state_e;

endpackage

`default_nettype wire

// File: verilog/rtr_sw_alloc.sv
// Router switch allocator
`default_nettype none

module rtr_sw_alloc
(
   input  wire logic                                          clk,
   input  wire logic                                          arst_n,
   input  wire rtr_pkg::port_vec_t                            req,
   input  wire rtr_pkg::port_vec_t                            tail,
   input  wire rtr_pkg::port_vec_t [rtr_pkg::num_ports-1:0]   route,
   input  wire rtr_pkg::port_vec_t                            credit_avail,
   output rtr_pkg::port_vec_t                                 pop,
   output rtr_pkg::port_vec_t                                 grant_valid,
   output rtr_pkg::port_idx_t [rtr_pkg::num_ports-1:0]        grant_ip
);

   // per output: round robin pointer and packet lock
   rtr_pkg::port_idx_t [rtr_pkg::num_ports-1:0] rr_ptr;
   rtr_pkg::port_idx_t [rtr_pkg::num_ports-1:0] lock_ip;
   rtr_pkg::port_vec_t                          lock_busy;

   // --------------------------------------------------
   // output-side arbitration
   // --------------------------------------------------

   always_comb
   begin
      int   cand;
      logic hit;
      for (int o = 0; o < rtr_pkg::num_ports; o++)
      begin
         cand = 0;
         hit = 1'b0;
         grant_ip[o] = lock_ip[o];
         if (lock_busy[o])
         begin
            // mid-packet: only the owner may send, and only with credit
            hit = req[lock_ip[o]] & route[lock_ip[o]][o] & credit_avail[o];
         end
         else if (credit_avail[o])
         begin
            // search starts one past the last winner
            for (int k = 1; k <= rtr_pkg::num_ports; k++)
            begin
               cand = (int'(rr_ptr[o]) + k) % rtr_pkg::num_ports;
               if (!hit && req[cand] && route[cand][o])
               begin
                  hit = 1'b1;
                  grant_ip[o] = rtr_pkg::port_idx_t'(cand);
               end
            end
         end
         grant_valid[o] = hit;
      end
   end

   // each input routes to one output, so grants never collide on an input
   always_comb
   begin
      pop = '0;
      for (int o = 0; o < rtr_pkg::num_ports; o++)
      begin
         if (grant_valid[o])
            pop[grant_ip[o]] = 1'b1;
      end
   end

   // --------------------------------------------------
   // lock and pointer state
   // --------------------------------------------------

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         // first search after reset starts at port 0
         rr_ptr <= {rtr_pkg::num_ports{rtr_pkg::port_idx_t'(rtr_pkg::num_ports - 1)}};
         lock_ip <= '0;
         lock_busy <= '0;
      end
      else
      begin
         for (int o = 0; o < rtr_pkg::num_ports; o++)
         begin
            if (grant_valid[o])
            begin
               rr_ptr[o] <= grant_ip[o];
               lock_ip[o] <= grant_ip[o];
               // tail frees the output for the next packet
               lock_busy[o] <= ~tail[grant_ip[o]];
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/rtr_top.sv
// Mesh router top level
`default_nettype none

module rtr_top
(
   input  wire logic                                          clk,
   input  wire logic                                          arst_n,
   input  wire rtr_pkg::router_addr_t                         router_address,
   input  wire rtr_pkg::port_vec_t                            channel_valid_in,
   input  wire rtr_pkg::port_vec_t                            channel_head_in,
   input  wire rtr_pkg::port_vec_t                            channel_tail_in,
   input  wire rtr_pkg::flit_data_t [rtr_pkg::num_ports-1:0]  channel_data_in,
   output rtr_pkg::port_vec_t                                 flow_ctrl_out,
   output rtr_pkg::port_vec_t                                 channel_valid_out,
   output rtr_pkg::port_vec_t                                 channel_head_out,
   output rtr_pkg::port_vec_t                                 channel_tail_out,
   output rtr_pkg::flit_data_t [rtr_pkg::num_ports-1:0]       channel_data_out,
   input  wire rtr_pkg::port_vec_t                            flow_ctrl_in,
   output logic                                               error
);

   // input side to allocator and crossbar
   rtr_pkg::port_vec_t                          ipc_req;
   rtr_pkg::port_vec_t [rtr_pkg::num_ports-1:0] ipc_route;
   rtr_pkg::port_vec_t                          ipc_head;
   rtr_pkg::port_vec_t                          ipc_tail;
   rtr_pkg::flit_data_t [rtr_pkg::num_ports-1:0] ipc_data;
   rtr_pkg::port_vec_t                          ipc_err_overflow;
   rtr_pkg::port_vec_t                          ipc_err_framing;

   // allocator decisions
   rtr_pkg::port_vec_t                          alo_pop;
   rtr_pkg::port_vec_t                          alo_grant_valid;
   rtr_pkg::port_idx_t [rtr_pkg::num_ports-1:0] alo_grant_ip;

   // output side status
   rtr_pkg::port_vec_t                          opc_credit_avail;
   rtr_pkg::port_vec_t                          opc_err_credit;

   // --------------------------------------------------
   // input controllers
   // --------------------------------------------------

   for (genvar ip = 0; ip < rtr_pkg::num_ports; ip++)
   begin : g_ip
      rtr_ip_ctrl u_ipc
      (
         .clk            (clk),
         .arst_n         (arst_n),
         .router_address (router_address),
         .flit_valid     (channel_valid_in[ip]),
         .flit_head      (channel_head_in[ip]),
         .flit_tail      (channel_tail_in[ip]),
         .flit_data      (channel_data_in[ip]),
         .pop            (alo_pop[ip]),
         .req            (ipc_req[ip]),
         .route          (ipc_route[ip]),
         .head_out       (ipc_head[ip]),
         .tail_out       (ipc_tail[ip]),
         .data_out       (ipc_data[ip]),
         .credit_out     (flow_ctrl_out[ip]),
         .err_overflow   (ipc_err_overflow[ip]),
         .err_framing    (ipc_err_framing[ip])
      );
   end

   // --------------------------------------------------
   // switch allocation
   // --------------------------------------------------

   rtr_sw_alloc u_alo
   (
      .clk          (clk),
      .arst_n       (arst_n),
      .req          (ipc_req),
      .tail         (ipc_tail),
      .route        (ipc_route),
      .credit_avail (opc_credit_avail),
      .pop          (alo_pop),
      .grant_valid  (alo_grant_valid),
      .grant_ip     (alo_grant_ip)
   );

   // --------------------------------------------------
   // output controllers, each holds one crossbar column
   // --------------------------------------------------

   for (genvar op = 0; op < rtr_pkg::num_ports; op++)
   begin : g_op
      rtr_op_ctrl u_opc
      (
         .clk           (clk),
         .arst_n        (arst_n),
         .grant_valid   (alo_grant_valid[op]),
         .grant_ip      (alo_grant_ip[op]),
         .head_in       (ipc_head),
         .tail_in       (ipc_tail),
         .data_in       (ipc_data),
         .flow_ctrl     (flow_ctrl_in[op]),
         .channel_valid (channel_valid_out[op]),
         .channel_head  (channel_head_out[op]),
         .channel_tail  (channel_tail_out[op]),
         .channel_data  (channel_data_out[op]),
         .credit_avail  (opc_credit_avail[op]),
         .err_credit    (opc_err_credit[op])
      );
   end

   // credit errors high, framing middle, overflow low
   rtr_err_rpt u_err
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .errors_in ({opc_err_credit, ipc_err_framing, ipc_err_overflow}),
      .error     (error)
   );

endmodule

`default_nettype wire
